/* design/gb_sys_pkg.sv */
// --------------------
// gb system package
// console address map, register addresses, interrupt
// bit positions, reset values and the bus glue enums
// --------------------
package gb_sys_pkg;

	// --------------------
	// widths
	localparam int ADDR_W      = 16;     // cpu address
	localparam int DATA_W      = 8;
	localparam int ZP_ADDR_W   = 7;      // 127 bytes at ff80
	localparam int WRAM_ADDR_W = 15;     // 3 bank bits + 12 offset bits
	localparam int IRQ_N       = 5;      // vblank, lcdc, timer, serial, joypad

	// read value of anything unmapped or absent
	localparam logic [DATA_W-1:0] OPEN_BUS_DATA   = 8'hff;
	localparam logic [2:0]        WRAM_BANK_RESET = 3'd1;   // svbk never holds 0

	// --------------------
	// register addresses
	localparam logic [ADDR_W-1:0] REG_JOYP = 16'hff00;   // joypad select
	localparam logic [ADDR_W-1:0] REG_IF   = 16'hff0f;   // interrupt flags
	localparam logic [ADDR_W-1:0] REG_VBK  = 16'hff4f;   // vram bank, colour only
	localparam logic [ADDR_W-1:0] REG_SVBK = 16'hff70;   // wram bank, colour only
	localparam logic [ADDR_W-1:0] REG_FF72 = 16'hff72;
	localparam logic [ADDR_W-1:0] REG_FF73 = 16'hff73;
	localparam logic [ADDR_W-1:0] REG_FF74 = 16'hff74;
	localparam logic [ADDR_W-1:0] REG_FF75 = 16'hff75;   // bits 6..4 only
	localparam logic [ADDR_W-1:0] REG_IE   = 16'hffff;   // interrupt enable

	// vector of source n is base + n * step
	localparam logic [DATA_W-1:0] IRQ_VEC_BASE = 8'h40;
	localparam int                IRQ_VEC_STEP = 8;

	// --------------------
	// enums
	typedef enum logic [2:0] {
		REGION_NONE,
		REGION_ZPRAM,
		REGION_WRAM,
		REGION_IO,
		REGION_IRQ
	} bus_region_e;

	typedef enum logic [3:0] {
		IO_NONE,
		IO_JOYP,
		IO_VBK,
		IO_SVBK,
		IO_FF72,
		IO_FF73,
		IO_FF74,
		IO_FF75,
		IO_IF,
		IO_IE
	} io_reg_e;

	// lowest position wins
	typedef enum logic [2:0] {
		IRQ_VBLANK = 3'd0,
		IRQ_LCDC   = 3'd1,
		IRQ_TIMER  = 3'd2,
		IRQ_SERIAL = 3'd3,
		IRQ_JOYPAD = 3'd4
	} irq_src_e;

	typedef enum logic [1:0] {
		APB_IDLE,
		APB_WAIT,     // strobes go out, ram read in flight
		APB_DONE      // pready high, prdata valid
	} apb_state_e;

endpackage

/* design/gb_bus_decode.sv */
`timescale 1ns/1ps
// --------------------
// gb bus decode
// apb slave front end for the console address map
// region and register decode, one-cycle strobes to the
// targets and read data return with one fixed wait state
// --------------------
module gb_bus_decode (
	input  logic                            clk_sys,
	input  logic                            reset_ss,
	input  logic                            is_gbc_i,    // colour model strap

	// apb slave
	input  logic [gb_sys_pkg::ADDR_W-1:0]   paddr_i,
	input  logic                            psel_i,
	input  logic                            penable_i,
	input  logic                            pwrite_i,
	input  logic [gb_sys_pkg::DATA_W-1:0]   pwdata_i,
	output logic [gb_sys_pkg::DATA_W-1:0]   prdata_o,
	output logic                            pready_o,

	// target side
	input  logic [gb_sys_pkg::DATA_W-1:0]   ram_rdata_i,
	input  logic [gb_sys_pkg::DATA_W-1:0]   io_rdata_i,
	input  logic [gb_sys_pkg::DATA_W-1:0]   irq_rdata_i,
	output logic [gb_sys_pkg::ADDR_W-1:0]   addr_o,
	output logic [gb_sys_pkg::DATA_W-1:0]   wdata_o,
	output logic                            wr_en_o,
	output logic                            rd_en_o,
	output gb_sys_pkg::bus_region_e         region_o,
	output gb_sys_pkg::io_reg_e             reg_sel_o
);

	gb_sys_pkg::apb_state_e  state_q;
	gb_sys_pkg::bus_region_e region_d, region_q;
	gb_sys_pkg::io_reg_e     reg_sel_d, reg_sel_q;

	logic [gb_sys_pkg::ADDR_W-1:0] addr_q;
	logic [gb_sys_pkg::DATA_W-1:0] wdata_q;
	logic                          write_q;
	logic                          start;

	// first access cycle seen while idle
	assign start = (state_q == gb_sys_pkg::APB_IDLE) && psel_i && penable_i;

	// --------------------
	// address decode
	always_comb begin
		reg_sel_d = gb_sys_pkg::IO_NONE;
		region_d  = gb_sys_pkg::REGION_NONE;

		// named registers, colour ones vanish on the monochrome model
		case (paddr_i)
			gb_sys_pkg::REG_JOYP: reg_sel_d = gb_sys_pkg::IO_JOYP;
			gb_sys_pkg::REG_IF:   reg_sel_d = gb_sys_pkg::IO_IF;
			gb_sys_pkg::REG_IE:   reg_sel_d = gb_sys_pkg::IO_IE;
			gb_sys_pkg::REG_VBK:  if (is_gbc_i) reg_sel_d = gb_sys_pkg::IO_VBK;
			gb_sys_pkg::REG_SVBK: if (is_gbc_i) reg_sel_d = gb_sys_pkg::IO_SVBK;
			gb_sys_pkg::REG_FF72: if (is_gbc_i) reg_sel_d = gb_sys_pkg::IO_FF72;
			gb_sys_pkg::REG_FF73: if (is_gbc_i) reg_sel_d = gb_sys_pkg::IO_FF73;
			gb_sys_pkg::REG_FF74: if (is_gbc_i) reg_sel_d = gb_sys_pkg::IO_FF74;
			gb_sys_pkg::REG_FF75: if (is_gbc_i) reg_sel_d = gb_sys_pkg::IO_FF75;
			default: reg_sel_d = gb_sys_pkg::IO_NONE;
		endcase

		if (paddr_i[15:7] == 9'h1ff && paddr_i != gb_sys_pkg::REG_IE) begin
			region_d = gb_sys_pkg::REGION_ZPRAM;   // ff80..fffe
		end else if (paddr_i[15:14] == 2'b11 && !(&paddr_i[13:9])) begin
			region_d = gb_sys_pkg::REGION_WRAM;    // c000..fdff incl. echo
		end else if (reg_sel_d == gb_sys_pkg::IO_IF || reg_sel_d == gb_sys_pkg::IO_IE) begin
			region_d = gb_sys_pkg::REGION_IRQ;
		end else if (reg_sel_d != gb_sys_pkg::IO_NONE) begin
			region_d = gb_sys_pkg::REGION_IO;
		end
	end

	// --------------------
	// apb state machine
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			state_q   <= gb_sys_pkg::APB_IDLE;
			region_q  <= gb_sys_pkg::REGION_NONE;
			reg_sel_q <= gb_sys_pkg::IO_NONE;
		end else begin
			case (state_q)
				gb_sys_pkg::APB_IDLE: begin
					if (start) begin
						state_q   <= gb_sys_pkg::APB_WAIT;
						region_q  <= region_d;     // held for the read mux
						reg_sel_q <= reg_sel_d;
					end
				end
				gb_sys_pkg::APB_WAIT: state_q <= gb_sys_pkg::APB_DONE;
				gb_sys_pkg::APB_DONE: state_q <= gb_sys_pkg::APB_IDLE;  // host drops penable
				default:              state_q <= gb_sys_pkg::APB_IDLE;
			endcase
		end
	end

	// transfer payload
	always_ff @(posedge clk_sys) begin
		if (start) begin
			addr_q  <= paddr_i;
			wdata_q <= pwdata_i;
			write_q <= pwrite_i;
		end
	end

	assign addr_o    = addr_q;
	assign wdata_o   = wdata_q;
	assign region_o  = region_q;
	assign reg_sel_o = reg_sel_q;

	// single cycle strobes in the wait state
	assign wr_en_o = (state_q == gb_sys_pkg::APB_WAIT) && write_q;
	assign rd_en_o = (state_q == gb_sys_pkg::APB_WAIT) && !write_q;

	assign pready_o = (state_q == gb_sys_pkg::APB_DONE);

	// read data return
	always_comb begin
		case (region_q)
			gb_sys_pkg::REGION_ZPRAM,
			gb_sys_pkg::REGION_WRAM: prdata_o = ram_rdata_i;   // registered ram output
			gb_sys_pkg::REGION_IO:   prdata_o = io_rdata_i;
			gb_sys_pkg::REGION_IRQ:  prdata_o = irq_rdata_i;
			default:                 prdata_o = gb_sys_pkg::OPEN_BUS_DATA;
		endcase
	end

	// --------------------
	// host holds the access phase until it sees pready
	a_pready_in_access: assert property (@(posedge clk_sys) disable iff (reset_ss)
		pready_o |-> (psel_i && penable_i));

	// strobe matches the direction the host still holds, so never both
	a_strobe_excl: assert property (@(posedge clk_sys) disable iff (reset_ss)
		(wr_en_o || rd_en_o) |-> (wr_en_o == pwrite_i) && (rd_en_o == !pwrite_i));

endmodule

/* design/gb_irq_ctrl.sv */
`timescale 1ns/1ps
// --------------------
// gb interrupt controller
// IF and IE registers, rising edge capture on four sources,
// joypad falling edge, priority vector and acknowledge
// --------------------
module gb_irq_ctrl (
	input  logic                            clk_sys,
	input  logic                            reset_ss,
	input  gb_sys_pkg::io_reg_e             reg_sel_i,
	input  logic                            wr_en_i,
	input  logic [gb_sys_pkg::DATA_W-1:0]   wdata_i,
	input  logic                            vblank_irq_i,
	input  logic                            lcdc_irq_i,
	input  logic                            timer_irq_i,
	input  logic                            serial_irq_i,
	input  logic [3:0]                      joy_din_i,   // p10..p13, low when pressed
	input  logic                            irq_ack_i,
	output logic [gb_sys_pkg::DATA_W-1:0]   irq_rdata_o,
	output logic                            irq_o,
	output logic [gb_sys_pkg::DATA_W-1:0]   irq_vector_o
);

	localparam int DW = gb_sys_pkg::DATA_W;

	logic [gb_sys_pkg::IRQ_N-1:0]  if_q;       // flags
	logic [gb_sys_pkg::DATA_W-1:0] ie_q;       // all 8 bits kept
	logic [gb_sys_pkg::IRQ_N-1:0]  pend;       // pending and enabled
	logic [gb_sys_pkg::IRQ_N-1:0]  set_mask;
	logic [gb_sys_pkg::IRQ_N-1:0]  clr_mask;
	logic                          vblank_q, lcdc_q, timer_q, serial_q;
	logic                          ack_q;
	logic [3:0]                    joy_q1, joy_q2;

	assign pend  = if_q & ie_q[gb_sys_pkg::IRQ_N-1:0];
	assign irq_o = |pend;

	// --------------------
	// event edges
	always_comb begin
		set_mask = '0;
		set_mask[gb_sys_pkg::IRQ_VBLANK] = vblank_irq_i & ~vblank_q;
		set_mask[gb_sys_pkg::IRQ_LCDC]   = lcdc_irq_i & ~lcdc_q;
		set_mask[gb_sys_pkg::IRQ_TIMER]  = timer_irq_i & ~timer_q;
		set_mask[gb_sys_pkg::IRQ_SERIAL] = serial_irq_i & ~serial_q;
		set_mask[gb_sys_pkg::IRQ_JOYPAD] = |(joy_q2 & ~joy_q1);   // any line went low
	end

	// falling ack clears only the lowest set pending bit
	assign clr_mask = (ack_q && !irq_ack_i) ? (pend & (~pend + 1'b1)) : '0;

	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			if_q     <= '0;
			ie_q     <= '0;
			vblank_q <= 1'b0;
			lcdc_q   <= 1'b0;
			timer_q  <= 1'b0;
			serial_q <= 1'b0;
			ack_q    <= 1'b0;
			joy_q1   <= '0;
			joy_q2   <= '0;
		end else begin
			vblank_q <= vblank_irq_i;
			lcdc_q   <= lcdc_irq_i;
			timer_q  <= timer_irq_i;
			serial_q <= serial_irq_i;
			ack_q    <= irq_ack_i;
			joy_q1   <= joy_din_i;      // two stage history
			joy_q2   <= joy_q1;

			if_q <= (if_q | set_mask) & ~clr_mask;   // ack clear beats a new edge

			// host writes win over events and ack
			if (wr_en_i && reg_sel_i == gb_sys_pkg::IO_IF)
				if_q <= wdata_i[gb_sys_pkg::IRQ_N-1:0];
			if (wr_en_i && reg_sel_i == gb_sys_pkg::IO_IE)
				ie_q <= wdata_i;
		end
	end

	// --------------------
	// vector, lowest bit has priority
	always_comb begin
		irq_vector_o = '0;
		for (int n = gb_sys_pkg::IRQ_N - 1; n >= 0; n--) begin
			if (pend[n])
				irq_vector_o = DW'(gb_sys_pkg::IRQ_VEC_BASE + n * gb_sys_pkg::IRQ_VEC_STEP);
		end
	end

	// register read, unused IF bits read 1
	always_comb begin
		case (reg_sel_i)
			gb_sys_pkg::IO_IF: irq_rdata_o = {{(DW - gb_sys_pkg::IRQ_N){1'b1}}, if_q};
			gb_sys_pkg::IO_IE: irq_rdata_o = ie_q;
			default:           irq_rdata_o = gb_sys_pkg::OPEN_BUS_DATA;
		endcase
	end

	a_irq_has_vector: assert property (@(posedge clk_sys) disable iff (reset_ss)
		irq_o |-> (irq_vector_o != '0));

endmodule

/* design/gb_io_regs.sv */
`timescale 1ns/1ps
// --------------------
// gb io registers
// joypad select, vram and wram bank registers
// and the spare colour model registers ff72..ff75
// --------------------
module gb_io_regs (
	input  logic                            clk_sys,
	input  logic                            reset_ss,
	input  gb_sys_pkg::io_reg_e             reg_sel_i,
	input  logic                            wr_en_i,
	input  logic [gb_sys_pkg::DATA_W-1:0]   wdata_i,
	input  logic [3:0]                      joy_din_i,
	output logic [gb_sys_pkg::DATA_W-1:0]   io_rdata_o,
	output logic [1:0]                      joy_p54_o,
	output logic                            vram_bank_o,
	output logic [2:0]                      wram_bank_o
);

	logic [1:0] p54_q;      // p14/p15 select lines
	logic       vbk_q;
	logic [2:0] svbk_q;     // 1..7
	logic [7:0] ff72_q, ff73_q, ff74_q;
	logic [2:0] ff75_q;     // bits 6..4 only

	// --------------------
	// register writes
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			p54_q  <= '0;
			vbk_q  <= 1'b0;
			svbk_q <= gb_sys_pkg::WRAM_BANK_RESET;
			ff72_q <= '0;
			ff73_q <= '0;
			ff74_q <= '0;
			ff75_q <= '0;
		end else if (wr_en_i) begin
			case (reg_sel_i)
				gb_sys_pkg::IO_JOYP: p54_q <= wdata_i[5:4];
				gb_sys_pkg::IO_VBK:  vbk_q <= wdata_i[0];
				gb_sys_pkg::IO_SVBK: begin
					if (wdata_i[2:0] == 3'd0)
						svbk_q <= gb_sys_pkg::WRAM_BANK_RESET;   // bank 0 not selectable
					else
						svbk_q <= wdata_i[2:0];
				end
				gb_sys_pkg::IO_FF72: ff72_q <= wdata_i;
				gb_sys_pkg::IO_FF73: ff73_q <= wdata_i;
				gb_sys_pkg::IO_FF74: ff74_q <= wdata_i;
				gb_sys_pkg::IO_FF75: ff75_q <= wdata_i[6:4];
				default: ;
			endcase
		end
	end

	assign joy_p54_o   = p54_q;
	assign vram_bank_o = vbk_q;
	assign wram_bank_o = svbk_q;

	// --------------------
	// read formats, unused bits read 1
	always_comb begin
		case (reg_sel_i)
			gb_sys_pkg::IO_JOYP: io_rdata_o = {2'b11, p54_q, joy_din_i};
			gb_sys_pkg::IO_VBK:  io_rdata_o = {7'h7f, vbk_q};
			gb_sys_pkg::IO_SVBK: io_rdata_o = {5'h1f, svbk_q};
			gb_sys_pkg::IO_FF72: io_rdata_o = ff72_q;
			gb_sys_pkg::IO_FF73: io_rdata_o = ff73_q;
			gb_sys_pkg::IO_FF74: io_rdata_o = ff74_q;
			gb_sys_pkg::IO_FF75: io_rdata_o = {1'b1, ff75_q, 4'hf};
			default:             io_rdata_o = gb_sys_pkg::OPEN_BUS_DATA;
		endcase
	end

	// bank 0 must never reach the d000 window
	a_wram_bank_nz: assert property (@(posedge clk_sys) disable iff (reset_ss)
		wram_bank_o != 3'd0);

endmodule

/* design/gb_ram_block.sv */
`timescale 1ns/1ps
// --------------------
// gb ram block
// 127 byte zero page ram and 32k banked work ram,
// both with one-cycle synchronous reads
// --------------------
module gb_ram_block (
	input  logic                            clk_sys,
	input  gb_sys_pkg::bus_region_e         region_i,
	input  logic [gb_sys_pkg::ADDR_W-1:0]   addr_i,
	input  logic [gb_sys_pkg::DATA_W-1:0]   wdata_i,
	input  logic                            wr_en_i,
	input  logic                            rd_en_i,
	input  logic [2:0]                      wram_bank_i,
	output logic [gb_sys_pkg::DATA_W-1:0]   ram_rdata_o
);

	logic [gb_sys_pkg::DATA_W-1:0] zp_mem   [0:(2**gb_sys_pkg::ZP_ADDR_W)-2];
	logic [gb_sys_pkg::DATA_W-1:0] wram_mem [0:(2**gb_sys_pkg::WRAM_ADDR_W)-1];

	logic [gb_sys_pkg::ZP_ADDR_W-1:0]   zp_idx;
	logic [gb_sys_pkg::WRAM_ADDR_W-1:0] wram_idx;
	logic [gb_sys_pkg::DATA_W-1:0]      zp_q, wram_q;
	gb_sys_pkg::bus_region_e            rd_sel_q;   // which array the last read hit

	assign zp_idx = addr_i[gb_sys_pkg::ZP_ADDR_W-1:0];   // ffff never decodes here

	// c000/e000 window is bank 0, d000/f000 window follows svbk
	// echo range lands on the same cells since only a12..a0 are used
	assign wram_idx = addr_i[12] ? {wram_bank_i, addr_i[11:0]}
	                             : {3'd0, addr_i[11:0]};

	// --------------------
	// zero page
	always_ff @(posedge clk_sys) begin
		if (wr_en_i && region_i == gb_sys_pkg::REGION_ZPRAM)
			zp_mem[zp_idx] <= wdata_i;
		if (rd_en_i)
			zp_q <= zp_mem[zp_idx];
	end

	// --------------------
	// work ram
	always_ff @(posedge clk_sys) begin
		if (wr_en_i && region_i == gb_sys_pkg::REGION_WRAM)
			wram_mem[wram_idx] <= wdata_i;
		if (rd_en_i)
			wram_q <= wram_mem[wram_idx];
	end

	always_ff @(posedge clk_sys) begin
		if (rd_en_i)
			rd_sel_q <= region_i;
	end

	assign ram_rdata_o = (rd_sel_q == gb_sys_pkg::REGION_ZPRAM) ? zp_q : wram_q;

endmodule

/* design/gb_sys_top.sv */
`timescale 1ns/1ps
// --------------------
// gb system top
// apb front end feeding ram, io and interrupt targets
// --------------------
module gb_sys_top (
	input  logic                            clk_sys,
	input  logic                            reset_ss,
	input  logic                            is_gbc_i,
	input  logic [gb_sys_pkg::ADDR_W-1:0]   paddr_i,
	input  logic                            psel_i,
	input  logic                            penable_i,
	input  logic                            pwrite_i,
	input  logic [gb_sys_pkg::DATA_W-1:0]   pwdata_i,
	input  logic [3:0]                      joy_din_i,
	input  logic                            vblank_irq_i,
	input  logic                            lcdc_irq_i,
	input  logic                            timer_irq_i,
	input  logic                            serial_irq_i,
	input  logic                            irq_ack_i,
	output logic [gb_sys_pkg::DATA_W-1:0]   prdata_o,
	output logic                            pready_o,
	output logic [1:0]                      joy_p54_o,
	output logic                            vram_bank_o,
	output logic                            irq_o,
	output logic [gb_sys_pkg::DATA_W-1:0]   irq_vector_o
);

	// --------------------
	// target bus
	logic [gb_sys_pkg::ADDR_W-1:0] addr;
	logic [gb_sys_pkg::DATA_W-1:0] wdata;
	logic                          wr_en, rd_en;
	gb_sys_pkg::bus_region_e       region;
	gb_sys_pkg::io_reg_e           reg_sel;
	logic [gb_sys_pkg::DATA_W-1:0] ram_rdata, io_rdata, irq_rdata;
	logic [2:0]                    wram_bank;   // svbk into the ram index

	gb_bus_decode u_bus_decode (
		.clk_sys     (clk_sys),
		.reset_ss    (reset_ss),
		.is_gbc_i    (is_gbc_i),
		.paddr_i     (paddr_i),
		.psel_i      (psel_i),
		.penable_i   (penable_i),
		.pwrite_i    (pwrite_i),
		.pwdata_i    (pwdata_i),
		.prdata_o    (prdata_o),
		.pready_o    (pready_o),
		.ram_rdata_i (ram_rdata),
		.io_rdata_i  (io_rdata),
		.irq_rdata_i (irq_rdata),
		.addr_o      (addr),
		.wdata_o     (wdata),
		.wr_en_o     (wr_en),
		.rd_en_o     (rd_en),
		.region_o    (region),
		.reg_sel_o   (reg_sel)
	);

	gb_irq_ctrl u_irq_ctrl (
		.clk_sys      (clk_sys),
		.reset_ss     (reset_ss),
		.reg_sel_i    (reg_sel),
		.wr_en_i      (wr_en),
		.wdata_i      (wdata),
		.vblank_irq_i (vblank_irq_i),
		.lcdc_irq_i   (lcdc_irq_i),
		.timer_irq_i  (timer_irq_i),
		.serial_irq_i (serial_irq_i),
		.joy_din_i    (joy_din_i),
		.irq_ack_i    (irq_ack_i),
		.irq_rdata_o  (irq_rdata),
		.irq_o        (irq_o),
		.irq_vector_o (irq_vector_o)
	);

	gb_io_regs u_io_regs (
		.clk_sys     (clk_sys),
		.reset_ss    (reset_ss),
		.reg_sel_i   (reg_sel),
		.wr_en_i     (wr_en),
		.wdata_i     (wdata),
		.joy_din_i   (joy_din_i),
		.io_rdata_o  (io_rdata),
		.joy_p54_o   (joy_p54_o),
		.vram_bank_o (vram_bank_o),
		.wram_bank_o (wram_bank)
	);

	gb_ram_block u_ram_block (
		.clk_sys     (clk_sys),
		.region_i    (region),
		.addr_i      (addr),
		.wdata_i     (wdata),
		.wr_en_i     (wr_en),
		.rd_en_i     (rd_en),
		.wram_bank_i (wram_bank),
		.ram_rdata_o (ram_rdata)
	);

endmodule

/* dv/gb_sys_checker.sv */
`timescale 1ns/1ps
// --------------------
// gb system checker
// reference model of the console map, compares prdata,
// interrupt outputs and bank pins at every clock edge
// --------------------
module gb_sys_checker (
	// ports named after the dut pins they watch
	input  logic                            clk_sys,
	input  logic                            reset_ss,
	input  logic                            is_gbc_i,
	input  logic [gb_sys_pkg::ADDR_W-1:0]   paddr_i,
	input  logic                            psel_i,
	input  logic                            penable_i,
	input  logic                            pwrite_i,
	input  logic [gb_sys_pkg::DATA_W-1:0]   pwdata_i,
	input  logic [3:0]                      joy_din_i,
	input  logic                            vblank_irq_i,
	input  logic                            lcdc_irq_i,
	input  logic                            timer_irq_i,
	input  logic                            serial_irq_i,
	input  logic                            irq_ack_i,
	input  logic [gb_sys_pkg::DATA_W-1:0]   prdata_o,
	input  logic                            pready_o,
	input  logic [1:0]                      joy_p54_o,
	input  logic                            vram_bank_o,
	input  logic                            irq_o,
	input  logic [gb_sys_pkg::DATA_W-1:0]   irq_vector_o,
	output int                              err_cnt_o
);

	logic [7:0] zp_m   [0:126];
	logic [7:0] wram_m [0:32767];
	logic [7:0] spare_m [0:3];      // ff72..ff75, ff75 masked on read
	logic [4:0] if_m;
	logic [7:0] ie_m;
	logic [1:0] p54_m;
	logic       vbk_m;
	logic [2:0] svbk_m;
	logic [3:0] src_prev, joy_prev;
	logic       ack_prev, joy_fall_d;
	int         acc_cnt;            // access phase edges of the current transfer

	initial err_cnt_o = 0;

	task automatic compare(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			$display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
			err_cnt_o++;
		end
	endtask

	// d000 window follows svbk, echo folds onto the same cells
	function automatic logic [14:0] wram_index(input logic [15:0] a);
		return a[12] ? {svbk_m, a[11:0]} : {3'd0, a[11:0]};
	endfunction

	function automatic int top_source(input logic [4:0] pend);
		for (int n = 0; n < gb_sys_pkg::IRQ_N; n++)
			if (pend[n])
				return n;
		return -1;
	endfunction

	function automatic logic [7:0] vector_of(input int top);
		if (top < 0)
			return 8'h00;
		return gb_sys_pkg::IRQ_VEC_BASE + 8'(top * gb_sys_pkg::IRQ_VEC_STEP);
	endfunction

	// --------------------
	// expected read data
	function automatic logic [7:0] ref_read(input logic [15:0] a);
		if (a >= 16'hff80 && a != 16'hffff)
			return zp_m[a[6:0]];
		if (a >= 16'hc000 && a < 16'hfe00)
			return wram_m[wram_index(a)];
		case (a)
			gb_sys_pkg::REG_JOYP: return {2'b11, p54_m, joy_din_i};
			gb_sys_pkg::REG_IF:   return {3'b111, if_m};
			gb_sys_pkg::REG_IE:   return ie_m;
			default: ;
		endcase
		if (!is_gbc_i)
			return gb_sys_pkg::OPEN_BUS_DATA;   // colour regs absent
		case (a)
			gb_sys_pkg::REG_VBK:  return {7'h7f, vbk_m};
			gb_sys_pkg::REG_SVBK: return {5'h1f, svbk_m};
			gb_sys_pkg::REG_FF72,
			gb_sys_pkg::REG_FF73,
			gb_sys_pkg::REG_FF74: return spare_m[a[3:0] - 4'd2];
			gb_sys_pkg::REG_FF75: return {1'b1, spare_m[3][6:4], 4'hf};
			default:              return gb_sys_pkg::OPEN_BUS_DATA;
		endcase
	endfunction

	task automatic model_write(input logic [15:0] a, input logic [7:0] d);
		if (a >= 16'hff80 && a != 16'hffff)
			zp_m[a[6:0]] = d;
		else if (a >= 16'hc000 && a < 16'hfe00)
			wram_m[wram_index(a)] = d;
		else case (a)
			gb_sys_pkg::REG_JOYP: p54_m = d[5:4];
			gb_sys_pkg::REG_IF:   if_m = d[4:0];      // beats events of the same edge
			gb_sys_pkg::REG_IE:   ie_m = d;
			gb_sys_pkg::REG_VBK:  if (is_gbc_i) vbk_m = d[0];
			gb_sys_pkg::REG_SVBK: if (is_gbc_i) svbk_m = (d[2:0] == 3'd0) ? 3'd1 : d[2:0];
			gb_sys_pkg::REG_FF72,
			gb_sys_pkg::REG_FF73,
			gb_sys_pkg::REG_FF74,
			gb_sys_pkg::REG_FF75: if (is_gbc_i) spare_m[a[3:0] - 4'd2] = d;
			default: ;
		endcase
	endtask

	// --------------------
	// per edge compare then model step
	always @(posedge clk_sys) begin : model_step
		logic [4:0] pend;
		logic [4:0] set_m;
		logic [4:0] clr_m;
		logic [3:0] src_now;
		logic       rdy_exp;
		int         top;
		src_now = {serial_irq_i, timer_irq_i, lcdc_irq_i, vblank_irq_i};
		if (reset_ss) begin
			if_m       = '0;
			ie_m       = '0;
			p54_m      = '0;
			vbk_m      = 1'b0;
			svbk_m     = 3'd1;
			spare_m    = '{default: 8'h00};
			joy_fall_d = 1'b0;
			acc_cnt    = 0;
		end else begin
			pend = if_m & ie_m[4:0];
			top  = top_source(pend);
			rdy_exp = psel_i && penable_i && (acc_cnt == 2);   // one wait state
			compare("irq_o", 8'(pend != 5'd0), 8'(irq_o));
			compare("irq_vector_o", vector_of(top), irq_vector_o);
			compare("vram_bank_o", 8'(vbk_m), 8'(vram_bank_o));
			compare("joy_p54_o", 8'(p54_m), 8'(joy_p54_o));
			compare("pready_o", 8'(rdy_exp), 8'(pready_o));
			if (rdy_exp && !pwrite_i)
				compare("prdata_o", ref_read(paddr_i), prdata_o);

			set_m = {joy_fall_d, src_now & ~src_prev};     // joypad one edge late
			clr_m = (ack_prev && !irq_ack_i && top >= 0) ? 5'(1 << top) : '0;
			if_m  = (if_m | set_m) & ~clr_m;

			if (rdy_exp) begin
				acc_cnt = 0;
			end else if (psel_i && penable_i) begin
				acc_cnt++;
				if (acc_cnt == 2 && pwrite_i)          // write lands at end of wait cycle
					model_write(paddr_i, pwdata_i);
			end
			joy_fall_d = |(joy_prev & ~joy_din_i);
		end
		joy_prev = joy_din_i;
		src_prev = src_now;
		ack_prev = irq_ack_i;
	end

endmodule

/* dv/gb_sys_tb.sv */
`timescale 1ns/1ps
// --------------------
// gb system testbench
// apb host for the console bus glue, runs the test
// sequence and prints the summary from the checker count
// --------------------
module gb_sys_tb;

	localparam int WAIT_LIMIT = 20;    // cycles per wait loop

	logic        clk_sys, reset_ss, is_gbc_i;
	logic [15:0] paddr_i;
	logic        psel_i, penable_i, pwrite_i;
	logic [7:0]  pwdata_i;
	logic [3:0]  joy_din_i;
	logic        vblank_irq_i, lcdc_irq_i, timer_irq_i, serial_irq_i, irq_ack_i;
	logic [7:0]  prdata_o, irq_vector_o;
	logic        pready_o, vram_bank_o, irq_o;
	logic [1:0]  joy_p54_o;

	int          err_cnt, err_mark, tests_run, tests_bad, seed;
	logic [15:0] zp_addr;
	logic [15:0] colour_regs [0:5];

	gb_sys_top DUT (.*);
	gb_sys_checker u_checker (.*, .err_cnt_o(err_cnt));

	always #20 clk_sys = ~clk_sys;

	task automatic abort_run(input string why);
		$display("timeout: %s", why);
		$display("Simulation failed");
		$finish;
	endtask

	// --------------------
	// apb host, drives on the falling edge
	task automatic apb_xfer(input logic wr, input logic [15:0] a, input logic [7:0] d);
		int n;
		@(negedge clk_sys);
		psel_i    = 1'b1;   // setup phase
		penable_i = 1'b0;
		pwrite_i  = wr;
		paddr_i   = a;
		pwdata_i  = d;
		@(negedge clk_sys);
		penable_i = 1'b1;
		n = 0;
		while (!pready_o && n < WAIT_LIMIT) begin
			@(negedge clk_sys);
			n++;
		end
		if (!pready_o) begin
			abort_run("pready_o never rose during an apb transfer");
		end else begin
			@(negedge clk_sys);   // slave samples pready on the edge in between
			psel_i    = 1'b0;
			penable_i = 1'b0;
			pwrite_i  = 1'b0;
		end
	endtask

	task automatic apb_write(input logic [15:0] a, input logic [7:0] d);
		apb_xfer(1'b1, a, d);
	endtask

	task automatic apb_read(input logic [15:0] a);
		apb_xfer(1'b0, a, 8'h00);
	endtask

	task automatic wait_irq();
		int n;
		n = 0;
		do begin
			@(negedge clk_sys);
			n++;
		end while (!irq_o && n < WAIT_LIMIT);
		if (!irq_o)
			abort_run("irq_o never rose after the source pulses");
	endtask

	task automatic hold_and_gap();
		repeat (3) @(negedge clk_sys);
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (err_cnt != err_mark)
			tests_bad++;
		$display("test %0d %s: %0d errors", tests_run, name, err_cnt - err_mark);
		err_mark = err_cnt;
	endtask

	// --------------------
	// test sequence
	initial begin
		clk_sys = 1'b0;
		reset_ss = 1'b1;
		is_gbc_i = 1'b1;
		paddr_i = '0;
		psel_i = 1'b0;
		penable_i = 1'b0;
		pwrite_i = 1'b0;
		pwdata_i = '0;
		joy_din_i = 4'hf;     // no buttons pressed
		vblank_irq_i = 1'b0;
		lcdc_irq_i = 1'b0;
		timer_irq_i = 1'b0;
		serial_irq_i = 1'b0;
		irq_ack_i = 1'b0;
		seed = 56;
		err_mark = 0;
		tests_run = 0;
		tests_bad = 0;
		colour_regs = '{gb_sys_pkg::REG_VBK, gb_sys_pkg::REG_SVBK, gb_sys_pkg::REG_FF72,
		                gb_sys_pkg::REG_FF73, gb_sys_pkg::REG_FF74, gb_sys_pkg::REG_FF75};
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		reset_ss = 1'b0;

		apb_read(gb_sys_pkg::REG_IF);
		apb_read(gb_sys_pkg::REG_IE);
		apb_read(gb_sys_pkg::REG_SVBK);
		apb_read(gb_sys_pkg::REG_VBK);
		apb_read(gb_sys_pkg::REG_FF75);
		apb_read(gb_sys_pkg::REG_JOYP);
		finish_test("reset values");

		apb_write(gb_sys_pkg::REG_JOYP, 8'h20);   // select lines out on joy_p54_o
		apb_read(gb_sys_pkg::REG_JOYP);
		apb_write(gb_sys_pkg::REG_SVBK, 8'h05);
		apb_write(gb_sys_pkg::REG_SVBK, 8'h00);   // becomes bank 1
		apb_read(gb_sys_pkg::REG_SVBK);
		apb_write(gb_sys_pkg::REG_VBK, 8'h01);
		for (int i = 2; i < 6; i++)
			apb_write(colour_regs[i], 8'($random(seed)));
		@(negedge clk_sys);
		is_gbc_i = 1'b0;                          // monochrome model
		foreach (colour_regs[i]) begin
			apb_write(colour_regs[i], 8'h06);
			apb_read(colour_regs[i]);
		end
		@(negedge clk_sys);
		is_gbc_i = 1'b1;
		foreach (colour_regs[i])
			apb_read(colour_regs[i]);
		finish_test("register masks and strap");

		apb_write(gb_sys_pkg::REG_SVBK, 8'h02);
		apb_write(16'hd000, 8'ha2);
		apb_write(gb_sys_pkg::REG_SVBK, 8'h03);
		apb_write(16'hd000, 8'h3c);
		apb_read(16'hd000);
		apb_write(gb_sys_pkg::REG_SVBK, 8'h02);
		apb_read(16'hd000);
		apb_write(16'hc000, 8'h5e);               // bank 0 window
		apb_write(gb_sys_pkg::REG_SVBK, 8'h03);
		apb_read(16'hc000);
		apb_read(16'he000);                       // echo of c000
		finish_test("work ram banking");

		for (int i = 0; i < 8; i++) begin
			zp_addr = 16'hff80 + 16'({$random(seed)} % 127);
			apb_write(zp_addr, 8'($random(seed)));
			apb_read(zp_addr);
		end
		apb_read(16'hff10);
		apb_read(16'h8000);
		finish_test("zero page and unmapped");

		apb_write(gb_sys_pkg::REG_IE, 8'h1f);
		@(negedge clk_sys);
		vblank_irq_i = 1'b1;
		timer_irq_i  = 1'b1;
		wait_irq();
		repeat (2) @(negedge clk_sys);
		vblank_irq_i = 1'b0;
		timer_irq_i  = 1'b0;
		hold_and_gap();
		@(negedge clk_sys);
		irq_ack_i = 1'b1;                         // falling edge clears vblank
		hold_and_gap();
		irq_ack_i = 1'b0;
		hold_and_gap();
		@(negedge clk_sys);
		joy_din_i = 4'hb;                         // one button pressed
		hold_and_gap();
		joy_din_i = 4'hf;
		hold_and_gap();
		apb_read(gb_sys_pkg::REG_IF);
		finish_test("interrupts");

		$display("tests run %0d, tests with errors %0d, mismatches %0d",
		         tests_run, tests_bad, err_cnt);
		if (err_cnt == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* gb_sys_top.f */
design/gb_sys_pkg.sv
design/gb_bus_decode.sv
design/gb_irq_ctrl.sv
design/gb_io_regs.sv
design/gb_ram_block.sv
design/gb_sys_top.sv
dv/gb_sys_checker.sv
dv/gb_sys_tb.sv
